//--- Bender.yml
package:
  name: tomasulo_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/inst_decode.sv
      - verilog/tag_regfile.sv
      - verilog/rs_bank.sv
      - verilog/alu_unit.sv
      - verilog/mul_unit.sv
      - verilog/cdb_arbiter.sv
      - verilog/tomasulo_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tomasulo_core_chk.sv
      - testbench/tb_tomasulo_core.sv

//--- src.f
+incdir+verilog
verilog/core_pkg.sv
verilog/inst_decode.sv
verilog/tag_regfile.sv
verilog/rs_bank.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/cdb_arbiter.sv
verilog/tomasulo_core.sv
testbench/tomasulo_core_chk.sv
testbench/tb_tomasulo_core.sv

//--- testbench/tb_tomasulo_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_tomasulo_core import core_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int NREG       = 1 << `REG_ADDR_W;
	localparam int STIM_MAX   = 32;
	localparam int TAG_LO     = `ALU_TAG_BASE;
	localparam int TAG_HI     = `MUL_TAG_BASE + `RS_PER_UNIT - 1;

	typedef enum logic [3:0] {
		K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_MUL,
		K_SLL, K_LW                                // Not supported by the core
	} kind_e;

	typedef struct packed {
		kind_e       kind;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [11:0] imm;
		word_t       inst;       // Encoded instruction word
		logic        wait_idle;  // Drain and check registers afterwards
	} stim_t;

	logic      clk;
	logic      rst_n;
	logic      inst_valid;
	word_t     inst;
	logic      issue_full;
	logic      busy;
	cdb_t      cdb;
	reg_addr_t reg_rd_addr;
	word_t     reg_rd_data;

	int          errors;
	int          assert_fails;       // Failures of the bound assertions
	int          cdb_pulses;
	int          n_issued;
	int          n_stim;
	logic [31:0] lfsr_state;
	word_t       model_regs [NREG];  // Sequential reference model
	stim_t       stim [STIM_MAX];

	tomasulo_core u_tomasulo_core (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
		.issue_full(issue_full), .busy(busy), .cdb(cdb),
		.reg_rd_addr(reg_rd_addr), .reg_rd_data(reg_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic check_word(word_t got, word_t exp, string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_tag(tag_t got, string what);
		if ($isunknown(got) || got < tag_t'(TAG_LO) || got > tag_t'(TAG_HI)) begin
			errors++;
			$display("FAILED at %0t ns: %s: tag %0d outside %0d to %0d",
				$time, what, got, TAG_LO, TAG_HI);
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
	endfunction

	task automatic draw_imm(output logic [11:0] imm);
		imm = '0;
		for (int i = 0; i < 12; i++) begin
			lfsr_state = lfsr_next(lfsr_state);          // One step per bit
			imm        = {imm[10:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t encode(stim_t e);
		case (e.kind)
			K_ADD:   return {7'b0000000, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011};
			K_SUB:   return {7'b0100000, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011};
			K_AND:   return {7'b0000000, e.rs2, e.rs1, 3'b111, e.rd, 7'b0110011};
			K_OR:    return {7'b0000000, e.rs2, e.rs1, 3'b110, e.rd, 7'b0110011};
			K_XOR:   return {7'b0000000, e.rs2, e.rs1, 3'b100, e.rd, 7'b0110011};
			K_MUL:   return {7'b0000001, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011};
			K_ADDI:  return {e.imm, e.rs1, 3'b000, e.rd, 7'b0010011};
			K_SLL:   return {7'b0000000, e.rs2, e.rs1, 3'b001, e.rd, 7'b0110011};
			default: return {e.imm, e.rs1, 3'b010, e.rd, 7'b0000011};  // LW
		endcase
	endfunction

	function automatic word_t expected_result(kind_e k, word_t a, word_t b, logic [11:0] imm);
		case (k)
			K_SUB:   return a - b;
			K_AND:   return a & b;
			K_OR:    return a | b;
			K_XOR:   return a ^ b;
			K_ADDI:  return a + {{20{imm[11]}}, imm};
			K_MUL:   return a * b;                     // Low 32 bits
			default: return a + b;
		endcase
	endfunction

	task automatic add_stim(kind_e k, int rd, int rs1, int rs2, logic idle);
		stim_t       e;
		logic [11:0] imm_v;
		imm_v = '0;
		if (k == K_ADDI)
			draw_imm(imm_v);
		e.kind      = k;
		e.rd        = reg_addr_t'(rd);
		e.rs1       = reg_addr_t'(rs1);
		e.rs2       = reg_addr_t'(rs2);
		e.imm       = imm_v;
		e.inst      = '0;
		e.wait_idle = idle;
		e.inst      = encode(e);
		stim[n_stim] = e;
		n_stim++;
	endtask

	task automatic build_stim();
		for (int r = 1; r <= 6; r++)                  // Independent ADDI
			add_stim(K_ADDI, r, 0, 0, r == 6);
		add_stim(K_ADD, 7, 1, 2, 0);                    // RAW chain
		add_stim(K_SUB, 8, 7, 3, 0);
		add_stim(K_AND, 9, 8, 4, 0);
		add_stim(K_OR, 10, 9, 5, 0);
		add_stim(K_XOR, 11, 10, 6, 0);
		add_stim(K_ADDI, 12, 11, 0, 1);
		add_stim(K_ADD, 13, 1, 2, 0);                   // ALU into MUL into ALU
		add_stim(K_MUL, 14, 13, 3, 0);
		add_stim(K_SUB, 15, 14, 1, 0);
		add_stim(K_MUL, 16, 14, 15, 1);
		add_stim(K_MUL, 5, 1, 2, 0);                    // WAW on x5
		add_stim(K_ADDI, 5, 0, 0, 0);
		add_stim(K_ADD, 0, 1, 2, 0);                    // x0 stays zero
		add_stim(K_SLL, 20, 1, 2, 0);
		add_stim(K_LW, 21, 1, 0, 0);
		add_stim(K_ADDI, 0, 3, 0, 1);
		add_stim(K_MUL, 17, 1, 2, 0);                   // Fills both MUL stations
		add_stim(K_MUL, 18, 2, 3, 0);
		add_stim(K_MUL, 19, 17, 18, 0);
		add_stim(K_ADD, 20, 19, 1, 0);
		add_stim(K_ADD, 21, 20, 17, 1);
	endtask

	task automatic apply_stim(stim_t e);
		@(negedge clk);
		inst_valid = 1'b0;                              // Ends the previous strobe
		inst       = e.inst;
		@(negedge clk);
		while (issue_full)
			@(negedge clk);
		inst_valid = 1'b1;
		if (e.kind != K_SLL && e.kind != K_LW) begin
			n_issued++;
			if (e.rd != '0)
				model_regs[e.rd] = expected_result(e.kind, model_regs[e.rs1],
					model_regs[e.rs2], e.imm);
		end
	endtask

	task automatic wait_idle();
		@(negedge clk);
		inst_valid = 1'b0;
		while (busy)
			@(negedge clk);
	endtask

	task automatic check_regs(string what);
		for (int i = 0; i < NREG; i++) begin
			reg_rd_addr = reg_addr_t'(i);
			@(negedge clk);
			check_word(reg_rd_data, model_regs[i], $sformatf("%s x%0d", what, i));
		end
	endtask

	// Every broadcast is one finished instruction
	always @(negedge clk) begin
		if (rst_n && cdb.valid === 1'b1) begin
			cdb_pulses++;
			check_tag(cdb.tag, "CDB tag");
		end
	end

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		rst_n        = 1'b0;
		inst_valid   = 1'b0;
		inst         = '0;
		reg_rd_addr  = '0;
		errors       = 0;
		assert_fails = 0;
		cdb_pulses   = 0;
		n_issued     = 0;
		n_stim       = 0;
		lfsr_state   = 32'd93442;
		for (int i = 0; i < NREG; i++)
			model_regs[i] = '0;
		build_stim();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_flag(cdb.valid, 1'b0, "cdb.valid after reset");
		check_flag(issue_full, 1'b0, "issue_full after reset");
		check_flag(busy, 1'b0, "busy after reset");
		check_regs("reset");
		for (int i = 0; i < n_stim; i++) begin
			apply_stim(stim[i]);
			if (stim[i].wait_idle) begin
				wait_idle();
				check_regs($sformatf("entry %0d", i));
			end
		end
		wait_idle();
		@(posedge clk);
		check_word(word_t'(cdb_pulses), word_t'(n_issued), "CDB pulse count");
		assert_fails = u_tomasulo_core.u_tomasulo_core_chk.fail_count;
		$display("Errors: %0d, assertion failures: %0d, CDB pulses: %0d, issued: %0d",
			errors, assert_fails, cdb_pulses, n_issued);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Limit scales with the table length
	initial begin
		#1;
		repeat (n_stim * 20) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", n_stim * 20);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- testbench/tomasulo_core_chk.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tomasulo_core_chk import core_pkg::*; #(
	parameter int FULL_MAX = 32  // Cycles until a full unit frees a station
) (
	input logic clk,
	input logic rst_n,
	input cdb_t cdb,
	input logic issue_full
);

	int fail_count = 0;  // Assertion failures so far

	// Tag 0 is the ready marker, never a producer
	a_cdb_tag_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.valid |-> cdb.tag != '0)
		else begin
			fail_count++;
			$error("CDB valid with tag 0");
		end

	a_issue_full_clears: assert property (@(posedge clk) disable iff (!rst_n)
		issue_full |-> ##[1:FULL_MAX] !issue_full)
		else begin
			fail_count++;
			$error("issue_full stuck high");
		end

endmodule

bind tomasulo_core tomasulo_core_chk u_tomasulo_core_chk (
	.clk(clk), .rst_n(rst_n), .cdb(cdb), .issue_full(issue_full)
);

//--- verilog/alu_unit.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_unit import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     issue,
	input  alu_op_e  op,
	input  operand_t a,
	input  operand_t b,
	output tag_t     issue_tag,
	output logic     all_busy,
	input  cdb_t     cdb,
	input  logic     alu_grant,   // Held result goes out now
	output cdb_t     result,
	output logic     empty
);

	exec_req_t req;
	word_t     alu_val;
	logic      accept;

	assign accept = ~result.valid | alu_grant;  // Slot free or leaving

	rs_bank #(.TAG_BASE(`ALU_TAG_BASE)) u_rs_bank (
		.clk(clk), .rst_n(rst_n), .issue(issue), .op(op), .a(a), .b(b),
		.issue_tag(issue_tag), .all_busy(all_busy), .empty(empty),
		.cdb(cdb), .accept(accept), .req(req)
	);

	always_comb begin
		case (req.op)
			SUB:     alu_val = req.a - req.b;
			AND:     alu_val = req.a & req.b;
			OR:      alu_val = req.a | req.b;
			XOR:     alu_val = req.a ^ req.b;
			default: alu_val = req.a + req.b;  // ADD and ADDI
		endcase
	end

	// One-entry holding register until granted
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result.valid <= 1'b0;
		end else if (req.valid) begin
			result <= '{valid: 1'b1, tag: req.tag, value: alu_val};
		end else if (alu_grant) begin
			result.valid <= 1'b0;
		end
	end

endmodule

//--- verilog/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter import core_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  cdb_t mul_res,    // One-cycle pulse from the pipeline
	input  cdb_t alu_res,    // Held until granted
	output logic alu_grant,
	output cdb_t cdb
);

	// Multiplier wins since it cannot wait
	assign alu_grant = alu_res.valid & ~mul_res.valid;

	// ------------------------------------------------------------
	// Registered bus
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cdb.valid <= 1'b0;
		end else if (mul_res.valid) begin
			cdb <= mul_res;
		end else if (alu_grant) begin
			cdb <= alu_res;
		end else begin
			cdb.valid <= 1'b0;     // Idle bus
		end
	end

endmodule

//--- verilog/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define XLEN          32   // Data word width
`define REG_ADDR_W    5    // 32 architectural registers
`define TAG_W         3    // Producer tag width, tag 0 means ready

// ------------------------------------------------------------
// Functional unit sizing
// ------------------------------------------------------------
`define RS_PER_UNIT   2    // Stations in each unit
`define ALU_TAG_BASE  1    // ALU owns tags 1 and 2
`define MUL_TAG_BASE  3    // Multiplier owns tags 3 and 4
`define MUL_STAGES    3    // Multiplier pipeline depth

`endif

//--- verilog/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

	// ------------------------------------------------------------
	// Scalar types
	// ------------------------------------------------------------
	typedef logic [`XLEN-1:0]       word_t;      // One data value
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // Register index
	typedef logic [`TAG_W-1:0]      tag_t;       // Producer tag

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4
	} alu_op_e;

	typedef enum logic [1:0] {
		NONE = 2'd0,   // Not issued
		ALU  = 2'd1,
		MUL  = 2'd2
	} unit_e;

	// ------------------------------------------------------------
	// Bundles
	// ------------------------------------------------------------
	typedef struct packed {
		tag_t  tag;    // Zero once the value is present
		word_t value;
	} operand_t;

	typedef struct packed {
		unit_e     unit;     // Target functional unit
		alu_op_e   alu_op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t     imm;      // Sign extended I-type immediate
		logic      use_imm;  // Operand b from imm
	} issue_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t value;
	} cdb_t;

	typedef struct packed {
		logic    valid;
		tag_t    tag;    // Destination tag of the station
		alu_op_e op;
		word_t   a;
		word_t   b;
	} exec_req_t;

endpackage

//--- verilog/inst_decode.sv
`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
	input  word_t  inst,
	output issue_t dec
);

	// RV32 opcode and funct fields
	localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ops
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ops
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB
	localparam logic [6:0] F7_MULDIV  = 7'b0000001;  // M extension

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		dec         = '0;                           // Unit NONE by default
		dec.rd      = inst[11:7];
		dec.rs1     = inst[19:15];
		dec.rs2     = inst[24:20];
		dec.imm     = {{20{inst[31]}}, inst[31:20]};  // Sign extend
		dec.alu_op  = ADD;
		dec.use_imm = 1'b0;
		case (opcode)
			OPC_OP: begin
				if (funct7 == F7_MULDIV && funct3 == 3'b000) begin
					dec.unit = MUL;                   // MUL
				end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
					dec.unit   = ALU;                 // SUB
					dec.alu_op = SUB;
				end else if (funct7 == F7_BASE) begin
					case (funct3)
						3'b000:  begin dec.unit = ALU; dec.alu_op = ADD; end
						3'b111:  begin dec.unit = ALU; dec.alu_op = AND; end
						3'b110:  begin dec.unit = ALU; dec.alu_op = OR;  end
						3'b100:  begin dec.unit = ALU; dec.alu_op = XOR; end
						default: dec.unit = NONE;       // Shifts and compares
					endcase
				end
			end
			OPC_OP_IMM: begin
				if (funct3 == 3'b000) begin         // ADDI only
					dec.unit    = ALU;
					dec.alu_op  = ADD;
					dec.use_imm = 1'b1;
				end
			end
			default: dec.unit = NONE;
		endcase
	end

endmodule

//--- verilog/mul_unit.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module mul_unit import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     issue,
	input  alu_op_e  op,
	input  operand_t a,
	input  operand_t b,
	output tag_t     issue_tag,
	output logic     all_busy,
	input  cdb_t     cdb,
	output cdb_t     result,      // Valid for one cycle
	output logic     empty
);

	localparam int S = `MUL_STAGES;

	exec_req_t       req;
	logic [S-1:0]    pipe_valid;
	tag_t            pipe_tag [S];
	word_t           pipe_val [S];

	// Pipeline never stalls so requests always go
	rs_bank #(.TAG_BASE(`MUL_TAG_BASE)) u_rs_bank (
		.clk(clk), .rst_n(rst_n), .issue(issue), .op(op), .a(a), .b(b),
		.issue_tag(issue_tag), .all_busy(all_busy), .empty(empty),
		.cdb(cdb), .accept(1'b1), .req(req)
	);

	// ------------------------------------------------------------
	// Product pipeline
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid[0] <= req.valid;
			for (int k = 1; k < S; k++) begin
				pipe_valid[k] <= pipe_valid[k-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		pipe_tag[0] <= req.tag;
		pipe_val[0] <= word_t'(req.a * req.b);  // Low 32 bits only
		for (int k = 1; k < S; k++) begin
			pipe_tag[k] <= pipe_tag[k-1];
			pipe_val[k] <= pipe_val[k-1];
		end
	end

	assign result = '{valid: pipe_valid[S-1], tag: pipe_tag[S-1], value: pipe_val[S-1]};

endmodule

//--- verilog/rs_bank.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module rs_bank import core_pkg::*; #(
	parameter int TAG_BASE = `ALU_TAG_BASE
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      issue,
	input  alu_op_e   op,
	input  operand_t  a,
	input  operand_t  b,
	output tag_t      issue_tag,
	output logic      all_busy,
	output logic      empty,
	input  cdb_t      cdb,
	input  logic      accept,     // Unit can take a request
	output exec_req_t req
);

	localparam int N     = `RS_PER_UNIT;
	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

	logic [N-1:0]     busy;        // Station holds an instruction
	logic [N-1:0]     dispatched;  // Sent to the unit
	logic [N-1:0]     ready;
	alu_op_e          ent_op [N];
	operand_t         ent_a  [N];
	operand_t         ent_b  [N];
	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] disp_idx;
	logic             has_free;
	logic             has_ready;

	// ------------------------------------------------------------
	// Lowest free and lowest ready station
	// ------------------------------------------------------------
	always_comb begin
		has_free  = 1'b0;
		has_ready = 1'b0;
		free_idx  = '0;
		disp_idx  = '0;
		for (int i = N - 1; i >= 0; i--) begin       // Last hit is lowest
			ready[i] = busy[i] & ~dispatched[i] & (ent_a[i].tag == '0) & (ent_b[i].tag == '0);
			if (!busy[i]) begin
				has_free = 1'b1;
				free_idx = IDX_W'(i);
			end
			if (ready[i]) begin
				has_ready = 1'b1;
				disp_idx  = IDX_W'(i);
			end
		end
		req.valid = has_ready & accept;
		req.tag   = tag_t'(TAG_BASE + int'(disp_idx));
		req.op    = ent_op[disp_idx];
		req.a     = ent_a[disp_idx].value;
		req.b     = ent_b[disp_idx].value;
	end

	assign issue_tag = tag_t'(TAG_BASE + int'(free_idx));
	assign all_busy  = ~has_free;
	assign empty     = ~|busy;

	// Station state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy       <= '0;
			dispatched <= '0;
		end else begin
			for (int i = 0; i < N; i++) begin
				if (cdb.valid && cdb.tag == tag_t'(TAG_BASE + i)) begin
					busy[i]       <= 1'b0;             // Freed on broadcast
					dispatched[i] <= 1'b0;
				end else if (req.valid && disp_idx == IDX_W'(i)) begin
					dispatched[i] <= 1'b1;
				end
			end
			if (issue && has_free) begin
				busy[free_idx]       <= 1'b1;
				dispatched[free_idx] <= 1'b0;
			end
		end
	end

	// Operand capture and CDB snoop
	always_ff @(posedge clk) begin
		for (int i = 0; i < N; i++) begin
			if (issue && has_free && free_idx == IDX_W'(i)) begin
				ent_op[i] <= op;
				ent_a[i]  <= a;
				ent_b[i]  <= b;
			end else begin
				if (cdb.valid && ent_a[i].tag != '0 && ent_a[i].tag == cdb.tag)
					ent_a[i] <= '{tag: '0, value: cdb.value};
				if (cdb.valid && ent_b[i].tag != '0 && ent_b[i].tag == cdb.tag)
					ent_b[i] <= '{tag: '0, value: cdb.value};
			end
		end
	end

endmodule

//--- verilog/tag_regfile.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tag_regfile import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	output operand_t  op_a,
	output operand_t  op_b,
	input  logic      rename,      // Issue strobe
	input  reg_addr_t rd,
	input  tag_t      rename_tag,
	input  cdb_t      cdb,
	input  reg_addr_t rd_addr,     // Debug read port
	output word_t     rd_data,
	output logic      pending      // Some register awaits a result
);

	localparam int NREG = 1 << `REG_ADDR_W;

	tag_t  reg_tag [NREG];  // Producer of the next value
	word_t reg_val [NREG];

	// Operand read with bypass of a broadcast in this cycle
	function automatic operand_t read_op(reg_addr_t addr);
		operand_t res;
		res.tag   = reg_tag[addr];
		res.value = reg_val[addr];
		if (cdb.valid && res.tag != '0 && res.tag == cdb.tag) begin
			res.tag   = '0;                  // Value arrives now
			res.value = cdb.value;
		end
		return res;
	endfunction

	always_comb begin
		op_a = read_op(rs1);
		op_b = read_op(rs2);
	end

	assign rd_data = reg_val[rd_addr];

	always_comb begin
		pending = 1'b0;
		for (int i = 0; i < NREG; i++) begin
			pending = pending | (|reg_tag[i]);
		end
	end

	// ------------------------------------------------------------
	// Rename at issue, retire on CDB match
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NREG; i++) begin
				reg_tag[i] <= '0;
				reg_val[i] <= '0;
			end
		end else begin
			for (int i = 1; i < NREG; i++) begin       // x0 never written
				if (cdb.valid && reg_tag[i] != '0 && reg_tag[i] == cdb.tag) begin
					reg_val[i] <= cdb.value;
					reg_tag[i] <= '0;
				end
				if (rename && rd == reg_addr_t'(i)) begin
					reg_tag[i] <= rename_tag;               // Overrides retire
				end
			end
		end
	end

endmodule

//--- verilog/tomasulo_core.sv
`timescale 1ns/1ps

module tomasulo_core import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_valid,   // One-cycle strobe
	input  word_t     inst,
	output logic      issue_full,   // Target unit has no free station
	output logic      busy,
	output cdb_t      cdb,
	input  reg_addr_t reg_rd_addr,
	output word_t     reg_rd_data
);

	issue_t   dec;
	operand_t op_a, op_b, op_b_sel;
	logic     issue_go, alu_issue, mul_issue;
	tag_t     alu_tag, mul_tag, rename_tag;
	logic     alu_all_busy, mul_all_busy;
	logic     alu_empty, mul_empty;
	logic     alu_grant, pending;
	cdb_t     alu_res, mul_res;

	// ------------------------------------------------------------
	// Issue
	// ------------------------------------------------------------
	assign issue_full = (dec.unit == ALU && alu_all_busy) || (dec.unit == MUL && mul_all_busy);
	assign issue_go   = inst_valid & ~issue_full & (dec.unit != NONE);
	assign alu_issue  = issue_go & (dec.unit == ALU);
	assign mul_issue  = issue_go & (dec.unit == MUL);
	assign rename_tag = (dec.unit == MUL) ? mul_tag : alu_tag;
	assign op_b_sel   = dec.use_imm ? '{tag: '0, value: dec.imm} : op_b;  // ADDI
	assign busy       = ~alu_empty | ~mul_empty | pending;

	inst_decode u_inst_decode (.inst(inst), .dec(dec));

	tag_regfile u_tag_regfile (
		.clk(clk), .rst_n(rst_n), .rs1(dec.rs1), .rs2(dec.rs2),
		.op_a(op_a), .op_b(op_b), .rename(issue_go), .rd(dec.rd),
		.rename_tag(rename_tag), .cdb(cdb), .rd_addr(reg_rd_addr),
		.rd_data(reg_rd_data), .pending(pending)
	);

	// ------------------------------------------------------------
	// Execute and result
	// ------------------------------------------------------------
	alu_unit u_alu_unit (
		.clk(clk), .rst_n(rst_n), .issue(alu_issue), .op(dec.alu_op),
		.a(op_a), .b(op_b_sel), .issue_tag(alu_tag), .all_busy(alu_all_busy),
		.cdb(cdb), .alu_grant(alu_grant), .result(alu_res), .empty(alu_empty)
	);

	mul_unit u_mul_unit (
		.clk(clk), .rst_n(rst_n), .issue(mul_issue), .op(dec.alu_op),
		.a(op_a), .b(op_b), .issue_tag(mul_tag), .all_busy(mul_all_busy),
		.cdb(cdb), .result(mul_res), .empty(mul_empty)
	);

	cdb_arbiter u_cdb_arbiter (
		.clk(clk), .rst_n(rst_n), .mul_res(mul_res), .alu_res(alu_res),
		.alu_grant(alu_grant), .cdb(cdb)
	);

endmodule
